// ==== filelist.f ====
+incdir+hdl
hdl/rvPkg.sv
hdl/fetchUnit.sv
hdl/pipeControl.sv
hdl/regFile.sv
hdl/execUnit.sv
hdl/dataMem.sv
hdl/rvPipeTop.sv
tb/rvPipe_chk.sv
tb/rvPipeMon.sv
tb/rvPipeTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rvPipeTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/rvPipeTb.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module rvPipeTb;

  localparam int NumTests = 6;

  logic                               clk = 1'b0;
  logic                               rstN;
  logic                               progWe;
  logic [$clog2(`RV_IMEM_WORDS)-1:0] progAddr;
  logic [31:0]                        progData;
  rvPkg::retireT                      retire;
  logic                               retireValid;
  rvPkg::storeT                       store;
  logic                               storeValid;

  // Program words, expected retire {rd, data} and store {addr, data}
  logic [31:0] progTab [NumTests][16];
  logic [36:0] retTab [NumTests][12];
  logic [63:0] stTab [NumTests][4];
  int          progLen [NumTests];
  int          retLen [NumTests];
  int          stLen [NumTests];
  logic [31:0] lfsr = 32'd96278;

  always #4 clk = ~clk;

  rvPipeTop dut (
    .clk         (clk),
    .rstN        (rstN),
    .progWe      (progWe),
    .progAddr    (progAddr),
    .progData    (progData),
    .retire      (retire),
    .retireValid (retireValid),
    .store       (store),
    .storeValid  (storeValid)
  );

  rvPipeMon mon (
    .clk         (clk),
    .rstN        (rstN),
    .retire      (retire),
    .retireValid (retireValid),
    .store       (store),
    .storeValid  (storeValid)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Instruction encoders
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [31:0] imm);
    return {imm[11:0], rs1, 3'b000, rd, 7'h13};
  endfunction

  function automatic logic [31:0] rOp(input logic [6:0] f7, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] lw(input logic [4:0] rd, input logic [4:0] rs1,
                                     input logic [31:0] imm);
    return {imm[11:0], rs1, 3'b010, rd, 7'h03};
  endfunction

  function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                     input logic [31:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [31:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] jal(input logic [4:0] rd, input logic [31:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  // Galois LFSR, one step per bit, 12 bits sign extended
  function automatic logic [31:0] randImm();
    logic [11:0] v;
    for (int i = 0; i < 12; i++) begin
      v[i] = lfsr[0];
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return {{20{v[11]}}, v};
  endfunction

  task automatic addWord(input int t, input logic [31:0] w);
    progTab[t][progLen[t]] = w;
    progLen[t]++;
  endtask

  task automatic addRet(input int t, input logic [4:0] rd, input logic [31:0] d);
    retTab[t][retLen[t]] = {rd, d};
    retLen[t]++;
  endtask

  task automatic addStore(input int t, input logic [31:0] a, input logic [31:0] d);
    stTab[t][stLen[t]] = {a, d};
    stLen[t]++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test table
  ////////////////////////////////////////////////////////////////////////////

  task automatic buildTable();
    logic [31:0] v [1:9];
    logic [31:0] i1;
    logic [31:0] i2;
    logic [31:0] i3;
    for (int t = 0; t < NumTests; t++) begin
      progLen[t] = 0;
      retLen[t]  = 0;
      stLen[t]   = 0;
    end
    // ALU chain on dependent registers
    i1 = randImm();
    i2 = randImm();
    i3 = randImm();
    v[1] = i1;
    v[2] = i2;
    v[3] = v[1] + v[2];
    v[4] = v[3] - v[1];
    v[5] = v[4] & v[3];
    v[6] = v[5] | v[2];
    v[7] = v[6] ^ v[4];
    v[8] = ($signed(v[7]) < $signed(v[3])) ? 32'd1 : 32'd0;
    v[9] = v[8] + i3;
    addWord(0, addi(1, 0, i1));
    addWord(0, addi(2, 0, i2));
    addWord(0, rOp(7'h00, 3'b000, 3, 1, 2));
    addWord(0, rOp(7'h20, 3'b000, 4, 3, 1));
    addWord(0, rOp(7'h00, 3'b111, 5, 4, 3));
    addWord(0, rOp(7'h00, 3'b110, 6, 5, 2));
    addWord(0, rOp(7'h00, 3'b100, 7, 6, 4));
    addWord(0, rOp(7'h00, 3'b010, 8, 7, 3));
    addWord(0, addi(9, 8, i3));
    addWord(0, jal(0, 0));
    for (int r = 1; r <= 9; r++) begin
      addRet(0, r[4:0], v[r]);
    end
    // Stores then loads
    addWord(1, addi(1, 0, 32'h55));
    addWord(1, addi(2, 0, -32'sd3));
    addWord(1, addi(10, 0, 32'd16));
    addWord(1, sw(1, 10, 0));
    addWord(1, sw(2, 10, 4));
    addWord(1, lw(3, 10, 0));
    addWord(1, lw(4, 10, 4));
    addWord(1, jal(0, 0));
    addRet(1, 1, 32'h55);
    addRet(1, 2, 32'hffff_fffd);
    addRet(1, 10, 32'd16);
    addRet(1, 3, 32'h55);
    addRet(1, 4, 32'hffff_fffd);
    addStore(1, 32'd16, 32'h55);
    addStore(1, 32'd20, 32'hffff_fffd);
    // Load-use
    addWord(2, addi(1, 0, 32'd100));
    addWord(2, addi(2, 0, 32'd7));
    addWord(2, sw(1, 0, 32'd32));
    addWord(2, lw(3, 0, 32'd32));
    addWord(2, rOp(7'h00, 3'b000, 4, 3, 2));
    addWord(2, rOp(7'h20, 3'b000, 5, 4, 3));
    addWord(2, jal(0, 0));
    addRet(2, 1, 32'd100);
    addRet(2, 2, 32'd7);
    addRet(2, 3, 32'd100);
    addRet(2, 4, 32'd107);
    addRet(2, 5, 32'd7);
    addStore(2, 32'd32, 32'd100);
    // BEQ taken at pc 8 to pc 20, BNE not taken
    addWord(3, addi(1, 0, 32'd5));
    addWord(3, addi(2, 0, 32'd5));
    addWord(3, branch(3'b000, 1, 2, 32'd12));
    addWord(3, addi(3, 0, 32'd1));
    addWord(3, addi(4, 0, 32'd2));
    addWord(3, addi(5, 0, 32'd3));
    addWord(3, branch(3'b001, 1, 2, 32'd8));
    addWord(3, addi(6, 0, 32'd4));
    addWord(3, jal(0, 0));
    addRet(3, 1, 32'd5);
    addRet(3, 2, 32'd5);
    addRet(3, 5, 32'd3);
    addRet(3, 6, 32'd4);
    // JAL at pc 4 to pc 16 links pc plus 4
    addWord(4, addi(1, 0, 32'd9));
    addWord(4, jal(5, 32'd12));
    addWord(4, addi(2, 0, 32'd1));
    addWord(4, addi(3, 0, 32'd2));
    addWord(4, addi(6, 5, 32'd1));
    addWord(4, jal(0, 0));
    addRet(4, 1, 32'd9);
    addRet(4, 5, 32'd8);
    addRet(4, 6, 32'd9);
    // x0 stays zero
    addWord(5, addi(1, 0, 32'd33));
    addWord(5, addi(0, 1, 32'd5));
    addWord(5, rOp(7'h00, 3'b000, 2, 0, 1));
    addWord(5, addi(3, 0, 32'd0));
    addWord(5, jal(0, 0));
    addRet(5, 1, 32'd33);
    addRet(5, 2, 32'd33);
    addRet(5, 3, 32'd0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reset, load and run
  ////////////////////////////////////////////////////////////////////////////

  task automatic loadProgram(input int t);
    for (int i = 0; i < 16; i++) begin
      @(posedge clk);
      rstN <= 1'b0;
      progWe <= (i < progLen[t]);
      progAddr <= i[$clog2(`RV_IMEM_WORDS)-1:0];
      progData <= progTab[t][i];
    end
    @(posedge clk);
    progWe <= 1'b0;
    rstN <= 1'b1;
  endtask

  initial begin
    int failedTests;
    int totalErr;
    int errBefore;
    int timeoutErr;
    int waitCycles;
    rstN = 1'b0;
    progWe = 1'b0;
    progAddr = '0;
    progData = '0;
    failedTests = 0;
    totalErr = 0;
    buildTable();
    for (int t = 0; t < NumTests; t++) begin
      errBefore = mon.errCount;
      timeoutErr = 0;
      for (int r = 0; r < retLen[t]; r++) begin
        mon.expectRetire(retTab[t][r][36:32], retTab[t][r][31:0]);
      end
      for (int s = 0; s < stLen[t]; s++) begin
        mon.expectStore(stTab[t][s][63:32], stTab[t][s][31:0]);
      end
      loadProgram(t);
      waitCycles = 0;
      while (mon.pendingCount() != 0 && waitCycles < 200) begin
        @(negedge clk);
        waitCycles++;
      end
      if (mon.pendingCount() != 0) begin
        $display("timeout: %0d events still missing in test %0d", mon.pendingCount(), t);
        timeoutErr = 1;
        mon.retQ.delete();
        mon.stQ.delete();
      end
      // Drain window catches late extra events
      waitCycles = 0;
      while (waitCycles < 10) begin
        @(negedge clk);
        waitCycles++;
      end
      if (mon.errCount - errBefore + timeoutErr == 0) begin
        $display("test %0d passed", t);
      end else begin
        $display("test %0d failed with %0d errors", t, mon.errCount - errBefore + timeoutErr);
        failedTests++;
      end
      totalErr += mon.errCount - errBefore + timeoutErr;
    end
    $display("tests %0d, failed %0d, errors %0d", NumTests, failedTests, totalErr);
    if (totalErr == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== tb/rvPipeMon.sv ====
`timescale 1ns/1ps

module rvPipeMon (
  input logic          clk,
  input logic          rstN,
  input rvPkg::retireT retire,
  input logic          retireValid,
  input rvPkg::storeT  store,
  input logic          storeValid
);

  logic [36:0] retQ [$];
  logic [63:0] stQ [$];
  int          errCount = 0;

  task automatic expectRetire(input logic [4:0] rd, input logic [31:0] data);
    retQ.push_back({rd, data});
  endtask

  task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
    stQ.push_back({addr, data});
  endtask

  function automatic int pendingCount();
    return retQ.size() + stQ.size();
  endfunction

  // Events are compared in program order
  always @(posedge clk) begin
    logic [36:0] r;
    logic [63:0] s;
    if (rstN === 1'b1 && retireValid) begin
      if (retQ.size() == 0) begin
        $display("unexpected retire to x%0d", retire.rd);
        errCount++;
      end else begin
        r = retQ.pop_front();
        if (retire.rd !== r[36:32]) begin
          $display("FAILED retire.rd exp 0x%h got 0x%h", r[36:32], retire.rd);
          errCount++;
        end
        if (retire.data !== r[31:0]) begin
          $display("FAILED retire.data exp 0x%h got 0x%h", r[31:0], retire.data);
          errCount++;
        end
      end
    end
    if (rstN === 1'b1 && storeValid) begin
      if (stQ.size() == 0) begin
        $display("unexpected store to address 0x%h", store.addr);
        errCount++;
      end else begin
        s = stQ.pop_front();
        if (store.addr !== s[63:32]) begin
          $display("FAILED store.addr exp 0x%h got 0x%h", s[63:32], store.addr);
          errCount++;
        end
        if (store.data !== s[31:0]) begin
          $display("FAILED store.data exp 0x%h got 0x%h", s[31:0], store.data);
          errCount++;
        end
      end
    end
  end

endmodule

// ==== tb/rvPipe_chk.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module rvPipeChk (
  input logic         clk,
  input logic         rstN,
  input logic         stall,
  input logic         flush,
  input logic         redirect,
  input rvPkg::fetchT fetchOut,
  input rvPkg::ctrlT  exCtrl
);

  // A load-use bubble resolves the hazard in one cycle
  stallOnce: assert property (@(posedge clk) disable iff (!rstN) stall |=> !stall)
    else $error("stall held for two consecutive cycles");

  resetQuiet: assert property (@(posedge clk) $rose(rstN) |-> (!stall && !flush))
    else $error("stall or flush high right after reset");

  // A redirect leaves bubbles in IF/ID and ID/EX on the next edge
  flushFollows: assert property (@(posedge clk) disable iff (!rstN)
    redirect |=> (fetchOut.instr == `RV_NOP && exCtrl == '0))
    else $error("redirect did not flush IF/ID and ID/EX");

endmodule

bind pipeControl rvPipeChk chk (
  .clk      (clk),
  .rstN     (rstN),
  .stall    (stall),
  .flush    (flush),
  .redirect (redirect),
  .fetchOut (fetchOut),
  .exCtrl   (exCtrl)
);

// ==== hdl/rvPipeTop.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module rvPipeTop (
  input  logic                               clk,
  input  logic                               rstN,
  input  logic                               progWe,
  input  logic [$clog2(`RV_IMEM_WORDS)-1:0] progAddr,
  input  logic [31:0]                        progData,
  output rvPkg::retireT                      retire,
  output logic                               retireValid,
  output rvPkg::storeT                       store,
  output logic                               storeValid
);

  rvPkg::fetchT        fetchOut;
  rvPkg::exOperT       exOper;
  rvPkg::ctrlT         exCtrl;
  rvPkg::ctrlT         memCtrl;
  rvPkg::fwdSelE       fwdA;
  rvPkg::fwdSelE       fwdB;
  rvPkg::fwdSelE       fwdStore;
  rvPkg::memReqT       memReq;
  logic [`RV_XLEN-1:0] regData1;
  logic [`RV_XLEN-1:0] regData2;
  logic [`RV_XLEN-1:0] redirectPc;
  logic                redirect;
  logic                stall;
  logic                flush;

  // Flush is the redirect seen by the front end
  fetchUnit uFetch (
    .clk        (clk),
    .rstN       (rstN),
    .progWe     (progWe),
    .progAddr   (progAddr),
    .progData   (progData),
    .stall      (stall),
    .redirect   (flush),
    .redirectPc (redirectPc),
    .fetchOut   (fetchOut)
  );

  pipeControl uCtrl (
    .clk      (clk),
    .rstN     (rstN),
    .fetchOut (fetchOut),
    .regData1 (regData1),
    .regData2 (regData2),
    .redirect (redirect),
    .exOper   (exOper),
    .exCtrl   (exCtrl),
    .memCtrl  (memCtrl),
    .fwdA     (fwdA),
    .fwdB     (fwdB),
    .fwdStore (fwdStore),
    .stall    (stall),
    .flush    (flush)
  );

  regFile uRegs (
    .clk         (clk),
    .rstN        (rstN),
    .rs1         (fetchOut.instr[19:15]),
    .rs2         (fetchOut.instr[24:20]),
    .retire      (retire),
    .retireValid (retireValid),
    .rdata1      (regData1),
    .rdata2      (regData2)
  );

  execUnit uExec (
    .clk        (clk),
    .rstN       (rstN),
    .exOper     (exOper),
    .exCtrl     (exCtrl),
    .fwdA       (fwdA),
    .fwdB       (fwdB),
    .fwdStore   (fwdStore),
    .retire     (retire),
    .memReq     (memReq),
    .redirect   (redirect),
    .redirectPc (redirectPc)
  );

  dataMem uMem (
    .clk         (clk),
    .rstN        (rstN),
    .memReq      (memReq),
    .memCtrl     (memCtrl),
    .retire      (retire),
    .retireValid (retireValid),
    .store       (store),
    .storeValid  (storeValid)
  );

endmodule

// ==== hdl/dataMem.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module dataMem (
  input  logic          clk,
  input  logic          rstN,
  input  rvPkg::memReqT memReq,
  input  rvPkg::ctrlT   memCtrl,
  output rvPkg::retireT retire,
  output logic          retireValid,
  output rvPkg::storeT  store,
  output logic          storeValid
);

  logic [`RV_XLEN-1:0]                dmem [`RV_DMEM_WORDS];
  logic [$clog2(`RV_DMEM_WORDS)-1:0] wordIdx;
  logic [`RV_XLEN-1:0]                loadData;
  logic [`RV_XLEN-1:0]                wbData;

  // Word addressed, low two bits ignored
  assign wordIdx  = memReq.aluResult[$clog2(`RV_DMEM_WORDS)+1:2];
  assign loadData = dmem[wordIdx];

  always_ff @(posedge clk) begin
    if (memCtrl.memWrite) begin
      dmem[wordIdx] <= memReq.storeData;
    end
  end

  // Store report in the MEM cycle
  assign store.addr = memReq.aluResult;
  assign store.data = memReq.storeData;
  assign storeValid = memCtrl.memWrite;

  always_comb begin
    case (memCtrl.wbSel)
      rvPkg::WbMem: wbData = loadData;
      rvPkg::WbPc4: wbData = memReq.pc + `RV_XLEN'd4;
      default:      wbData = memReq.aluResult;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // MEM/WB register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      retireValid <= 1'b0;
    end else begin
      retireValid <= memCtrl.regWrite && (memReq.rd != 5'd0);
    end
  end

  always_ff @(posedge clk) begin
    retire.rd   <= memReq.rd;
    retire.data <= wbData;
  end

endmodule

// ==== hdl/execUnit.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module execUnit (
  input  logic                clk,
  input  logic                rstN,
  input  rvPkg::exOperT       exOper,
  input  rvPkg::ctrlT         exCtrl,
  input  rvPkg::fwdSelE       fwdA,
  input  rvPkg::fwdSelE       fwdB,
  input  rvPkg::fwdSelE       fwdStore,
  input  rvPkg::retireT       retire,
  output rvPkg::memReqT       memReq,
  output logic                redirect,
  output logic [`RV_XLEN-1:0] redirectPc
);

  logic [`RV_XLEN-1:0] opA;
  logic [`RV_XLEN-1:0] rs2Val;
  logic [`RV_XLEN-1:0] opB;
  logic [`RV_XLEN-1:0] storeVal;
  logic [`RV_XLEN-1:0] aluResult;

  function automatic logic [`RV_XLEN-1:0] pick(input rvPkg::fwdSelE sel,
                                               input logic [`RV_XLEN-1:0] regVal);
    case (sel)
      rvPkg::FwdMem: return memReq.aluResult;
      rvPkg::FwdWb:  return retire.data;
      default:       return regVal;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Operands and ALU
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    opA      = pick(fwdA, exOper.rs1Data);
    rs2Val   = pick(fwdB, exOper.rs2Data);
    storeVal = pick(fwdStore, exOper.rs2Data);
    opB      = exCtrl.useImm ? exOper.imm : rs2Val;
  end

  always_comb begin
    case (exCtrl.aluOp)
      rvPkg::AluSub: aluResult = opA - opB;
      rvPkg::AluAnd: aluResult = opA & opB;
      rvPkg::AluOr:  aluResult = opA | opB;
      rvPkg::AluXor: aluResult = opA ^ opB;
      rvPkg::AluSlt: aluResult = {{(`RV_XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
      default:       aluResult = opA + opB;
    endcase
  end

  // BEQ / BNE compare and jump target
  assign redirect   = exCtrl.isJal ||
                      (exCtrl.isBranch && ((opA == rs2Val) != exCtrl.branchNe));
  assign redirectPc = exOper.pc + exOper.imm;

  ////////////////////////////////////////////////////////////////////////////
  // EX/MEM register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    memReq.aluResult <= aluResult;
    memReq.storeData <= storeVal;
    memReq.pc        <= exOper.pc;
    memReq.rd        <= exOper.rd;
    if (!rstN) begin
      memReq.rd <= '0;
    end
  end

endmodule

// ==== hdl/regFile.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module regFile (
  input  logic                clk,
  input  logic                rstN,
  input  logic [4:0]          rs1,
  input  logic [4:0]          rs2,
  input  rvPkg::retireT       retire,
  input  logic                retireValid,
  output logic [`RV_XLEN-1:0] rdata1,
  output logic [`RV_XLEN-1:0] rdata2
);

  // x0 is not stored
  logic [`RV_XLEN-1:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (retireValid && retire.rd != 5'd0) begin
      regs[retire.rd] <= retire.data;
    end
  end

  // Same-cycle write shows up on the read side
  assign rdata1 = (rs1 == 5'd0) ? '0 :
                  (retireValid && retire.rd == rs1) ? retire.data : regs[rs1];
  assign rdata2 = (rs2 == 5'd0) ? '0 :
                  (retireValid && retire.rd == rs2) ? retire.data : regs[rs2];

endmodule

// ==== hdl/pipeControl.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module pipeControl (
  input  logic                clk,
  input  logic                rstN,
  input  rvPkg::fetchT        fetchOut,
  input  logic [`RV_XLEN-1:0] regData1,
  input  logic [`RV_XLEN-1:0] regData2,
  input  logic                redirect,
  output rvPkg::exOperT       exOper,
  output rvPkg::ctrlT         exCtrl,
  output rvPkg::ctrlT         memCtrl,
  output rvPkg::fwdSelE       fwdA,
  output rvPkg::fwdSelE       fwdB,
  output rvPkg::fwdSelE       fwdStore,
  output logic                stall,
  output logic                flush
);

  logic [31:0]         instr;
  rvPkg::ctrlT         idCtrl;
  rvPkg::ctrlT         wbCtrl;
  logic                idValid;
  logic                usesRs1;
  logic                usesRs2;
  logic [`RV_XLEN-1:0] idImm;
  logic [4:0]          idRs1;
  logic [4:0]          idRs2;
  logic [4:0]          memRd;
  logic [4:0]          wbRd;

  assign instr = fetchOut.instr;
  assign idRs1 = instr[19:15];
  assign idRs2 = instr[24:20];

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    idCtrl  = '0;
    idValid = 1'b0;
    usesRs1 = 1'b0;
    usesRs2 = 1'b0;
    idImm   = {{20{instr[31]}}, instr[31:20]};
    case (rvPkg::opcodeE'(instr[6:0]))
      rvPkg::OpcOp: begin
        idCtrl.regWrite = 1'b1;
        usesRs1 = 1'b1;
        usesRs2 = 1'b1;
        idValid = 1'b1;
        case ({instr[31:25], instr[14:12]})
          {7'b0000000, 3'b000}: idCtrl.aluOp = rvPkg::AluAdd;
          {7'b0100000, 3'b000}: idCtrl.aluOp = rvPkg::AluSub;
          {7'b0000000, 3'b111}: idCtrl.aluOp = rvPkg::AluAnd;
          {7'b0000000, 3'b110}: idCtrl.aluOp = rvPkg::AluOr;
          {7'b0000000, 3'b100}: idCtrl.aluOp = rvPkg::AluXor;
          {7'b0000000, 3'b010}: idCtrl.aluOp = rvPkg::AluSlt;
          default:              idValid = 1'b0;
        endcase
      end
      rvPkg::OpcOpImm: begin
        // ADDI only
        idCtrl.useImm   = 1'b1;
        idCtrl.regWrite = 1'b1;
        usesRs1 = 1'b1;
        idValid = (instr[14:12] == 3'b000);
      end
      rvPkg::OpcLoad: begin
        idCtrl.useImm   = 1'b1;
        idCtrl.memRead  = 1'b1;
        idCtrl.regWrite = 1'b1;
        idCtrl.wbSel    = rvPkg::WbMem;
        usesRs1 = 1'b1;
        idValid = (instr[14:12] == 3'b010);
      end
      rvPkg::OpcStore: begin
        idCtrl.useImm   = 1'b1;
        idCtrl.memWrite = 1'b1;
        usesRs1 = 1'b1;
        usesRs2 = 1'b1;
        idImm   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        idValid = (instr[14:12] == 3'b010);
      end
      rvPkg::OpcBranch: begin
        idCtrl.isBranch = 1'b1;
        idCtrl.branchNe = instr[12];
        usesRs1 = 1'b1;
        usesRs2 = 1'b1;
        idImm   = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        idValid = (instr[14:13] == 2'b00);
      end
      rvPkg::OpcJal: begin
        idCtrl.isJal    = 1'b1;
        idCtrl.regWrite = 1'b1;
        idCtrl.wbSel    = rvPkg::WbPc4;
        idImm   = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        idValid = 1'b1;
      end
      default: idValid = 1'b0;
    endcase
  end

  // Load in EX feeding the instruction in ID
  assign stall = exCtrl.memRead && (exOper.rd != 5'd0) &&
                 ((usesRs1 && exOper.rd == idRs1) || (usesRs2 && exOper.rd == idRs2));
  assign flush = redirect;

  ////////////////////////////////////////////////////////////////////////////
  // ID/EX register and control pipe
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      exCtrl  <= '0;
      memCtrl <= '0;
      wbCtrl  <= '0;
    end else begin
      exCtrl  <= (flush || stall || !idValid) ? '0 : idCtrl;
      memCtrl <= exCtrl;
      wbCtrl  <= memCtrl;
    end
  end

  always_ff @(posedge clk) begin
    exOper.pc      <= fetchOut.pc;
    exOper.rs1Data <= regData1;
    exOper.rs2Data <= regData2;
    exOper.imm     <= idImm;
    exOper.rs1     <= idRs1;
    exOper.rs2     <= idRs2;
    exOper.rd      <= instr[11:7];
    memRd          <= exOper.rd;
    wbRd           <= memRd;
  end

  // MEM wins over WB; loads and JAL never forward from MEM
  function automatic rvPkg::fwdSelE fwdFor(input logic [4:0] rs);
    if (rs != 5'd0 && memCtrl.regWrite && memCtrl.wbSel == rvPkg::WbAlu && memRd == rs) begin
      return rvPkg::FwdMem;
    end
    if (rs != 5'd0 && wbCtrl.regWrite && wbRd == rs) begin
      return rvPkg::FwdWb;
    end
    return rvPkg::FwdReg;
  endfunction

  always_comb begin
    fwdA     = fwdFor(exOper.rs1);
    fwdB     = exCtrl.useImm ? rvPkg::FwdReg : fwdFor(exOper.rs2);
    fwdStore = exCtrl.memWrite ? fwdFor(exOper.rs2) : rvPkg::FwdReg;
  end

endmodule

// ==== hdl/fetchUnit.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module fetchUnit (
  input  logic                               clk,
  input  logic                               rstN,
  input  logic                               progWe,
  input  logic [$clog2(`RV_IMEM_WORDS)-1:0] progAddr,
  input  logic [31:0]                        progData,
  input  logic                               stall,
  input  logic                               redirect,
  input  logic [`RV_XLEN-1:0]                redirectPc,
  output rvPkg::fetchT                       fetchOut
);

  logic [31:0]                        imem [`RV_IMEM_WORDS];
  logic [`RV_XLEN-1:0]                pc;
  logic [$clog2(`RV_IMEM_WORDS)-1:0] fetchIdx;

  assign fetchIdx = pc[$clog2(`RV_IMEM_WORDS)+1:2];

  // Program load port, only open while the core is held in reset
  always_ff @(posedge clk) begin
    if (!rstN && progWe) begin
      imem[progAddr] <= progData;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Program counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc <= '0;
    end else if (redirect) begin
      pc <= redirectPc;
    end else if (!stall) begin
      pc <= pc + `RV_XLEN'd4;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN || redirect) begin
      // Wrong-path slot becomes a NOP
      fetchOut.pc    <= '0;
      fetchOut.instr <= `RV_NOP;
    end else if (!stall) begin
      fetchOut.pc    <= pc;
      fetchOut.instr <= imem[fetchIdx];
    end
  end

endmodule

// ==== hdl/rvPkg.sv ====
`include "rv_config.svh"

package rvPkg;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OpcOp     = 7'b0110011,
    OpcOpImm  = 7'b0010011,
    OpcLoad   = 7'b0000011,
    OpcStore  = 7'b0100011,
    OpcBranch = 7'b1100011,
    OpcJal    = 7'b1101111
  } opcodeE;

  typedef enum logic [2:0] {
    AluAdd,
    AluSub,
    AluAnd,
    AluOr,
    AluXor,
    AluSlt
  } aluOpE;

  // Operand source for EX
  typedef enum logic [1:0] {
    FwdReg,
    FwdMem,
    FwdWb
  } fwdSelE;

  typedef enum logic [1:0] {
    WbAlu,
    WbMem,
    WbPc4
  } wbSelE;

  // All zero is a bubble
  typedef struct packed {
    aluOpE aluOp;
    logic  useImm;
    logic  memRead;
    logic  memWrite;
    logic  regWrite;
    wbSelE wbSel;
    logic  isBranch;
    logic  branchNe;
    logic  isJal;
  } ctrlT;

  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    logic [31:0]         instr;
  } fetchT;

  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] rs1Data;
    logic [`RV_XLEN-1:0] rs2Data;
    logic [`RV_XLEN-1:0] imm;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [4:0]          rd;
  } exOperT;

  typedef struct packed {
    logic [`RV_XLEN-1:0] aluResult;
    logic [`RV_XLEN-1:0] storeData;
    logic [`RV_XLEN-1:0] pc;
    logic [4:0]          rd;
  } memReqT;

  typedef struct packed {
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] data;
  } retireT;

  typedef struct packed {
    logic [`RV_XLEN-1:0] addr;
    logic [`RV_XLEN-1:0] data;
  } storeT;

endpackage

// ==== hdl/rv_config.svh ====
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Datapath width
`define RV_XLEN 32

// Instruction memory depth in words
`define RV_IMEM_WORDS 64

// Data memory depth in words
`define RV_DMEM_WORDS 64

// ADDI x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif
